// ==== design/matmul_consts.svh ====
/* array geometry, run length, core count and fixed-point widths
   shared by the matmul subsystem */

`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

// grid and run sizes
`define MM_ARRAY_DIM 2   // rows and columns of one core.
`define MM_INNER_DIM 8   // operand vectors per run.
`define MM_NUM_CORES 2   // cores sharing the north stream.

// fixed point, signed Q8.8
`define MM_DATA_W 16     // operand and result width.
`define MM_FRAC_W 8      // fraction bits.
`define MM_ACC_W 40      // accumulator width, leaves headroom for the sum.

// sequencer
`define MM_CNT_W 5       // feed and flush counter width.

`endif

// ==== design/matmul_pkg.sv ====
/* fixed-point operand, accumulator and vector types
   plus the sequencer state encoding */

`include "matmul_consts.svh"

package matmul_pkg;

    typedef logic signed [`MM_DATA_W-1:0] fixed_t;  // one Q8.8 value.
    typedef logic signed [`MM_ACC_W-1:0]  acc_t;    // full-width running sum.

    // element i sits at bits [i*DATA_W +: DATA_W]
    typedef logic [`MM_ARRAY_DIM*`MM_DATA_W-1:0] vec_t;

    // element (i,j) sits at index i*ARRAY_DIM+j, row-major.
    typedef logic [`MM_ARRAY_DIM*`MM_ARRAY_DIM*`MM_DATA_W-1:0] result_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for start.
        FEED,   // operand vectors enter the array.
        FLUSH,  // skew drains, inputs are zero.
        LOAD    // results latch this cycle.
    } ctrl_state_t;

endpackage

// ==== design/systolic_pe.sv ====
/* one multiply-accumulate processing element with
   registered east and south operand pass-through */

`timescale 1ns/1ps

module systolic_pe (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  matmul_pkg::fixed_t a_in,
    input  matmul_pkg::fixed_t b_in,
    output matmul_pkg::fixed_t a_out,
    output matmul_pkg::fixed_t b_out,
    output matmul_pkg::acc_t   acc
);

    matmul_pkg::acc_t prod;  // product at accumulator width.

    // both factors widened first so the product keeps every bit.
    assign prod = matmul_pkg::acc_t'(a_in) * matmul_pkg::acc_t'(b_in);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in;         // to east neighbor.
            b_out <= b_in;         // to south neighbor.
            acc   <= acc + prod;   // zero operands leave it unchanged.
        end
    end

endmodule

// ==== design/systolic_core.sv ====
/* ARRAY_DIM x ARRAY_DIM output-stationary systolic core with triangular
   input skew and a rounding, saturating result register */

`timescale 1ns/1ps
`include "matmul_consts.svh"

module systolic_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                clear_acc,
    input  logic                load_result,
    input  matmul_pkg::vec_t    west,
    input  matmul_pkg::vec_t    north,
    output matmul_pkg::result_t result,
    output logic                saturated
);

    localparam int DIM   = `MM_ARRAY_DIM;
    localparam int W     = `MM_DATA_W;
    localparam int SHR_W = `MM_ACC_W - `MM_FRAC_W + 1;  // sum width after the shift.

    localparam logic signed [`MM_ACC_W:0] HALF_LSB = 1 <<< (`MM_FRAC_W - 1);
    localparam logic signed [SHR_W-1:0]   FIX_MAX  = (1 <<< (W - 1)) - 1;
    localparam logic signed [SHR_W-1:0]   FIX_MIN  = -(1 <<< (W - 1));

    matmul_pkg::fixed_t  a_h [DIM][DIM+1];  // west operands, last column unread.
    matmul_pkg::fixed_t  b_v [DIM+1][DIM];  // north operands, last row unread.
    matmul_pkg::acc_t    acc [DIM][DIM];
    matmul_pkg::result_t next_result;
    logic [DIM*DIM-1:0]  clip;              // per-element clamp flags.

    // row i passes i+1 registers, the first one being the capture stage
    for (genvar i = 0; i < DIM; i++) begin : g_west_skew
        matmul_pkg::fixed_t pipe [i+1];
        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s <= i; s++) begin
                    pipe[s] <= '0;
                end
            end else begin
                pipe[0] <= west[i*W +: W];
                for (int s = 1; s <= i; s++) begin
                    pipe[s] <= pipe[s-1];
                end
            end
        end
        assign a_h[i][0] = pipe[i];
    end

    for (genvar j = 0; j < DIM; j++) begin : g_north_skew
        matmul_pkg::fixed_t pipe [j+1];
        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s <= j; s++) begin
                    pipe[s] <= '0;
                end
            end else begin
                pipe[0] <= north[j*W +: W];
                for (int s = 1; s <= j; s++) begin
                    pipe[s] <= pipe[s-1];
                end
            end
        end
        assign b_v[0][j] = pipe[j];
    end

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col
            logic signed [`MM_ACC_W:0] rnd;    // sum plus half an lsb.
            logic signed [SHR_W-1:0]   shr;    // floor of rnd over 2^FRAC_W.
            matmul_pkg::fixed_t        sat_val;

            systolic_pe u_pe (
                .clk   (clk),
                .rst   (rst),
                .clear (clear_acc),
                .a_in  (a_h[i][j]),
                .b_in  (b_v[i][j]),
                .a_out (a_h[i][j+1]),
                .b_out (b_v[i+1][j]),
                .acc   (acc[i][j])
            );

            assign rnd = acc[i][j] + HALF_LSB;
            assign shr = rnd[`MM_ACC_W:`MM_FRAC_W];  // arithmetic shift by bit select.
            assign clip[i*DIM+j] = (shr > FIX_MAX) || (shr < FIX_MIN);
            assign sat_val = (shr > FIX_MAX) ? FIX_MAX[W-1:0] :
                             (shr < FIX_MIN) ? FIX_MIN[W-1:0] : shr[W-1:0];
            assign next_result[(i*DIM+j)*W +: W] = sat_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result    <= '0;
            saturated <= 1'b0;
        end else if (load_result) begin
            result    <= next_result;
            saturated <= |clip;  // any element clamped this run.
        end
    end

    // the sequencer never clears while it loads
    a_no_clear_on_load: assert property (
        @(posedge clk) disable iff (rst) !(clear_acc && load_result));

endmodule

// ==== design/multi_matmul_wrapper.sv ====
/* NUM_CORES systolic cores on one shared north stream with a west
   stream each, input gating and the OR of the saturation flags */

`timescale 1ns/1ps
`include "matmul_consts.svh"

module multi_matmul_wrapper (
    input  logic                clk,
    input  logic                rst,
    input  logic                feed,
    input  logic                clear_acc,
    input  logic                load_result,
    input  matmul_pkg::vec_t    input_w [`MM_NUM_CORES],
    input  matmul_pkg::vec_t    input_n,
    output matmul_pkg::result_t out_multi_matmul [`MM_NUM_CORES],
    output logic                sat_flag
);

    matmul_pkg::vec_t         north_g;                   // shared north, gated.
    matmul_pkg::vec_t         west_g [`MM_NUM_CORES];    // per-core west, gated.
    logic [`MM_NUM_CORES-1:0] core_sat;

    // zeros outside the feed window let the skew drain without adding
    assign north_g = feed ? input_n : '0;

    for (genvar c = 0; c < `MM_NUM_CORES; c++) begin : g_core
        assign west_g[c] = feed ? input_w[c] : '0;

        systolic_core u_core (
            .clk         (clk),
            .rst         (rst),
            .clear_acc   (clear_acc),
            .load_result (load_result),
            .west        (west_g[c]),
            .north       (north_g),
            .result      (out_multi_matmul[c]),
            .saturated   (core_sat[c])
        );
    end

    assign sat_flag = |core_sat;  // any core clamped.

endmodule

// ==== design/matmul_ctrl.sv ====
/* run sequencer: clears the accumulators, opens the feed window,
   waits out the skew and loads the results */

`timescale 1ns/1ps
`include "matmul_consts.svh"

module matmul_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic feed,
    output logic clear_acc,
    output logic load_result,
    output logic busy,
    output logic done
);

    localparam logic [`MM_CNT_W-1:0] FEED_LAST  = `MM_INNER_DIM - 1;
    localparam logic [`MM_CNT_W-1:0] FLUSH_LAST = 2 * `MM_ARRAY_DIM - 2;

    matmul_pkg::ctrl_state_t  state;
    logic [`MM_CNT_W-1:0]     cnt;   // cycles spent in FEED or FLUSH.

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= matmul_pkg::IDLE;
            cnt         <= '0;
            feed        <= 1'b0;
            clear_acc   <= 1'b0;
            load_result <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            clear_acc   <= 1'b0;         // single-cycle pulses by default.
            load_result <= 1'b0;
            done        <= load_result;  // one cycle behind the load.
            case (state)
                matmul_pkg::IDLE: begin
                    if (start) begin
                        state     <= matmul_pkg::FEED;
                        cnt       <= '0;
                        feed      <= 1'b1;
                        clear_acc <= 1'b1;
                        busy      <= 1'b1;
                    end
                end
                matmul_pkg::FEED: begin
                    if (cnt == FEED_LAST) begin
                        state <= matmul_pkg::FLUSH;
                        cnt   <= '0;
                        feed  <= 1'b0;   // last vector taken at this edge.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                matmul_pkg::FLUSH: begin
                    if (cnt == FLUSH_LAST) begin
                        state       <= matmul_pkg::LOAD;
                        cnt         <= '0;
                        load_result <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                matmul_pkg::LOAD: begin
                    state <= matmul_pkg::IDLE;
                    busy  <= 1'b0;       // falls with done rising.
                end
                default: state <= matmul_pkg::IDLE;
            endcase
        end
    end

    a_feed_done_excl: assert property (
        @(posedge clk) disable iff (rst) !(feed && done));

    a_done_single: assert property (
        @(posedge clk) disable iff (rst) done |=> !done);

endmodule

// ==== design/matmul_top.sv ====
/* matmul subsystem top: run sequencer driving the multi-core wrapper */

`timescale 1ns/1ps
`include "matmul_consts.svh"

module matmul_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  matmul_pkg::vec_t    a_col [`MM_NUM_CORES],
    input  matmul_pkg::vec_t    b_row,
    output logic                feed,
    output logic                busy,
    output logic                done,
    output matmul_pkg::result_t result [`MM_NUM_CORES],
    output logic                sat_flag
);

    logic clear_acc;    // accumulator clear pulse.
    logic load_result;  // result register load pulse.

    matmul_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .feed        (feed),
        .clear_acc   (clear_acc),
        .load_result (load_result),
        .busy        (busy),
        .done        (done)
    );

    multi_matmul_wrapper u_wrap (
        .clk              (clk),
        .rst              (rst),
        .feed             (feed),
        .clear_acc        (clear_acc),
        .load_result      (load_result),
        .input_w          (a_col),
        .input_n          (b_row),
        .out_multi_matmul (result),
        .sat_flag         (sat_flag)
    );

endmodule

// ==== verification/matmul_tb.sv ====
/* testbench for matmul_top with clock, reset, stimulus, reference model,
   timing and result assertions and a cycle limit */

`timescale 1ns/1ps
`include "matmul_consts.svh"

module matmul_tb;

    localparam int     DIM         = `MM_ARRAY_DIM;
    localparam int     INNER       = `MM_INNER_DIM;
    localparam int     CORES       = `MM_NUM_CORES;
    localparam int     W           = `MM_DATA_W;
    localparam int     ROWS        = CORES * DIM;
    localparam int     DONE_LAT    = INNER + 2 * DIM;  // edges from start to done.
    localparam int     NUM_RUNS    = 29;
    localparam int     CYCLE_LIMIT = NUM_RUNS * 40 + 100;
    localparam longint HALF_LSB    = longint'(1) << (`MM_FRAC_W - 1);
    localparam longint FIX_MAX     = (longint'(1) << (W - 1)) - 1;
    localparam longint FIX_MIN     = -(longint'(1) << (W - 1));

    logic                clk;
    logic                rst;
    logic                start;
    logic                feed;
    logic                busy;
    logic                done;
    logic                sat_flag;
    matmul_pkg::vec_t    a_col [CORES];
    matmul_pkg::vec_t    b_row;
    matmul_pkg::result_t result [CORES];

    matmul_pkg::fixed_t  a_mat [ROWS][INNER];
    matmul_pkg::fixed_t  b_mat [INNER][DIM];
    matmul_pkg::result_t exp_next [CORES];  // model output for the next run.
    matmul_pkg::result_t exp_cur [CORES];   // taken over when the DUT accepts start.
    logic                exp_sat_next;
    logic                exp_sat_cur;
    int                  edge_no  = 0;      // rising edges so far.
    int                  s_edge   = -100;   // edge that accepted the last start.
    int                  feed_run = 0;      // length of the current feed window.
    logic                rst_seen = 1'b0;   // reset sampled at the last edge.
    logic                exp_busy = 1'b0;   // a run is in progress.

    matmul_top DUT (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .a_col    (a_col),
        .b_row    (b_row),
        .feed     (feed),
        .busy     (busy),
        .done     (done),
        .result   (result),
        .sat_flag (sat_flag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // edge bookkeeping, read by the assertions on the falling edge
    always @(posedge clk) begin
        edge_no  <= edge_no + 1;
        rst_seen <= rst;
        if (rst) begin
            feed_run <= 0;
            s_edge   <= -100;
            exp_busy <= 1'b0;
        end else begin
            feed_run <= feed ? feed_run + 1 : 0;
            if (start && !exp_busy) begin
                s_edge      <= edge_no + 1;
                exp_busy    <= 1'b1;
                exp_cur     <= exp_next;
                exp_sat_cur <= exp_sat_next;
            end else if (edge_no + 1 == s_edge + DONE_LAT) begin
                exp_busy <= 1'b0;  // falls with done rising.
            end
        end
        if (edge_no >= CYCLE_LIMIT) begin
            stop_on_error("timeout: the runs did not finish within the cycle limit");
        end
    end

    a_done_time: assert property (@(negedge clk) disable iff (rst)
        done |-> edge_no == s_edge + DONE_LAT)
        else stop_on_error($sformatf("FAILED done at edge %h, expected edge %h",
                                     edge_no, s_edge + DONE_LAT));

    a_feed_len: assert property (@(negedge clk) disable iff (rst)
        $fell(feed) |-> feed_run == INNER)
        else stop_on_error($sformatf("FAILED feed high cycles = %h, expected %h",
                                     feed_run, INNER));

    a_busy: assert property (@(negedge clk) disable iff (rst)
        busy == exp_busy)
        else stop_on_error($sformatf("FAILED busy = %h, expected %h",
                                     busy, exp_busy));

    a_sat_flag: assert property (@(negedge clk) disable iff (rst)
        done |-> sat_flag == exp_sat_cur)
        else stop_on_error($sformatf("FAILED sat_flag = %h, expected %h",
                                     sat_flag, exp_sat_cur));

    a_reset_ctrl: assert property (@(negedge clk)
        rst_seen |-> !feed && !busy && !done && !sat_flag)
        else stop_on_error($sformatf("FAILED feed/busy/done/sat_flag = %h/%h/%h/%h, expected 0",
                                     feed, busy, done, sat_flag));

    for (genvar c = 0; c < CORES; c++) begin : g_check
        a_result: assert property (@(negedge clk) disable iff (rst)
            done |-> result[c] == exp_cur[c])
            else stop_on_error($sformatf("FAILED result[%0d] = %h, expected %h",
                                         c, result[c], exp_cur[c]));

        a_reset_result: assert property (@(negedge clk)
            rst_seen |-> result[c] == '0)
            else stop_on_error($sformatf("FAILED result[%0d] = %h after reset, expected 0",
                                         c, result[c]));
    end

    // round half up, shift out the fraction, clamp to 16 bits
    task automatic compute_expect();
        longint sum;
        longint q;
        exp_sat_next = 1'b0;
        for (int c = 0; c < CORES; c++) begin
            for (int i = 0; i < DIM; i++) begin
                for (int j = 0; j < DIM; j++) begin
                    sum = 0;
                    for (int k = 0; k < INNER; k++) begin
                        sum += longint'(a_mat[c*DIM+i][k]) * longint'(b_mat[k][j]);
                    end
                    q = (sum + HALF_LSB) >>> `MM_FRAC_W;
                    if (q > FIX_MAX || q < FIX_MIN) begin
                        exp_sat_next = 1'b1;
                        q = (q > FIX_MAX) ? FIX_MAX : FIX_MIN;
                    end
                    exp_next[c][(i*DIM+j)*W +: W] = 16'(q);
                end
            end
        end
    endtask

    task automatic fill_random(input int span);
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < INNER; k++) begin
                a_mat[r][k] = 16'(int'($urandom_range(0, 2 * span)) - span);
            end
        end
        for (int k = 0; k < INNER; k++) begin
            for (int j = 0; j < DIM; j++) begin
                b_mat[k][j] = 16'(int'($urandom_range(0, 2 * span)) - span);
            end
        end
    endtask

    task automatic fill_identity();
        for (int k = 0; k < INNER; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                a_mat[r][k] = (r == k) ? 16'sh0100 : 16'sh0000;  // 1.0 on the diagonal.
            end
            for (int j = 0; j < DIM; j++) begin
                b_mat[k][j] = 16'((k - 3) * 384 + j * 37);
            end
        end
    endtask

    // core 0 clamps high in column 0 and low in column 1, core 1 the reverse
    task automatic fill_saturating();
        for (int k = 0; k < INNER; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                a_mat[r][k] = (r < DIM) ? 16'sh7F00 : 16'sh8100;
            end
            b_mat[k][0] = 16'sh7F00;
            b_mat[k][1] = 16'sh8100;
        end
    endtask

    task automatic drive_vector(input int k);
        for (int c = 0; c < CORES; c++) begin
            for (int i = 0; i < DIM; i++) begin
                a_col[c][i*W +: W] = a_mat[c*DIM+i][k];
            end
        end
        for (int j = 0; j < DIM; j++) begin
            b_row[j*W +: W] = b_mat[k][j];
        end
    endtask

    task automatic drive_junk();
        for (int c = 0; c < CORES; c++) begin
            a_col[c] = matmul_pkg::vec_t'($urandom());  // gated off outside feed.
        end
        b_row = matmul_pkg::vec_t'($urandom());
    endtask

    // called on a falling edge, returns on the falling edge that sees done
    task automatic run_matmul(input bit poke_busy);
        int k;
        k = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (k < INNER) begin
            if (feed) begin
                drive_vector(k);
                k++;
            end else begin
                drive_junk();
            end
            start = poke_busy & busy & 1'($urandom_range(0, 1));
            @(negedge clk);
        end
        drive_junk();
        while (!done) begin
            start = poke_busy & busy & 1'($urandom_range(0, 1));
            @(negedge clk);
        end
        start = 1'b0;
    endtask

    task automatic abort_with_reset();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int k = 0; k < 3; k++) begin
            drive_vector(k);
            @(negedge clk);
        end
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    task automatic prepare_random();
        fill_random(16'h0300);  // +-3.0 keeps eight products in range.
        compute_expect();
    endtask

    initial begin
        void'($urandom(32'ha2cb_db9b));
        rst   = 1'b1;
        start = 1'b0;
        b_row = '0;
        for (int c = 0; c < CORES; c++) begin
            a_col[c] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        fill_identity();
        compute_expect();
        run_matmul(1'b0);

        repeat (20) begin
            prepare_random();
            repeat ($urandom_range(0, 2)) @(negedge clk);
            run_matmul(1'b0);
        end

        fill_saturating();
        compute_expect();
        run_matmul(1'b0);
        prepare_random();
        run_matmul(1'b0);  // sat_flag drops again.

        prepare_random();
        run_matmul(1'b1);  // start pulses while busy.
        repeat (2) begin
            prepare_random();
            run_matmul(1'b0);
        end

        fill_saturating();
        compute_expect();
        run_matmul(1'b0);  // sat_flag high when the reset hits.
        prepare_random();
        abort_with_reset();
        prepare_random();
        run_matmul(1'b0);

        repeat (2) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== matmul_array.f ====
+incdir+design
design/matmul_pkg.sv
design/systolic_pe.sv
design/systolic_core.sv
design/multi_matmul_wrapper.sv
design/matmul_ctrl.sv
design/matmul_top.sv
verification/matmul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the matmul testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=matmul_sim

if ! verilator --binary --timing --assert -j 0 \
        --top-module matmul_tb -f matmul_array.f \
        --Mdir obj_dir -o "$BIN"; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
